// ==== vlog.f ====
source/rv_isa_pkg.sv
source/fetch_pkg.sv
source/imem_sram.sv
source/btb.sv
source/pc_gen.sv
source/stage_if_sram.sv
source/if_id_reg.sv
source/early_jump.sv
source/fetch_unit.sv
test/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module fetch_tb \
  -f vlog.f --Mdir obj_dir -o fetch_sim || exit 1
out=$(./obj_dir/fetch_sim)
echo "$out"
echo "$out" | grep -qx "Done: no errors" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== test/fetch_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  // One table row
  // Stimulus for a cycle and what decode must hold after its edge
  typedef struct packed {
    int          test;
    logic        stall;
    logic        ex_v;
    logic        upd_v;
    logic        upd_tk;
    logic [31:0] ex_t;
    logic [31:0] upd_pc;
    logic [31:0] upd_t;
    logic        exp_valid;
    logic        exp_hit;
    logic        exp_taken;
    logic [31:0] exp_pc;
    logic [31:0] exp_instr;
    logic [31:0] exp_tgt;
  } row_t;

  // DUT inputs start idle with reset asserted
  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        id_stall = 1'b0;
  redirect_t   ex_redirect = '0;
  btb_update_t btb_update = '0;
  imem_wr_t    imem_wr = '0;
  if_bundle_t  id_out;

  row_t        rows [$];
  logic [31:0] img [imem_words];
  int          checks = 0;
  int          errors = 0;
  int          test_errs = 0;
  logic        table_ready = 1'b0;
  string       test_name [$] = '{"", "reset and sequential fetch", "stall",
                                 "execute redirect", "BTB training", "early jump",
                                 "redirect priority"};

  fetch_unit u_dut (.*);

  // 4 ns period
  always #2 clk = ~clk;

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      $display("MISMATCH t=%0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
      test_errs++;
    end
  endtask

  // Appends n identical cycles
  task automatic add_row(input int test, input int n, input int stall, input int ex_v,
                         input logic [31:0] ex_t, input int upd_v, input int upd_tk,
                         input logic [31:0] upd_pc, input logic [31:0] upd_t);
    repeat (n) begin
      rows.push_back('{test: test, stall: stall != 0, ex_v: ex_v != 0, ex_t: ex_t,
                       upd_v: upd_v != 0, upd_tk: upd_tk != 0, upd_pc: upd_pc,
                       upd_t: upd_t, default: '0});
    end
  endtask

  // Reference model of the front end over the whole table
  task automatic build_expected();
    logic [31:0] m_pc, id_pc, id_w, id_tgt, jimm, bimm, jr_t, nxt;
    logic [31:0] b_pc [16];
    logic [31:0] b_tgt [16];
    logic        b_v [16];
    logic        b_tk [16];
    logic        id_v, id_hit, id_tk, jr_v, hit, tk, flush;
    logic [3:0]  ix;
    m_pc = reset_pc;
    id_pc = '0;
    id_w = i_nop;
    id_tgt = '0;
    id_v = 1'b0;
    id_hit = 1'b0;
    id_tk = 1'b0;
    b_v = '{default: 1'b0};
    for (int i = 0; i < rows.size(); i++) begin
      // Immediates straight from the J and B formats
      jimm = {{12{id_w[31]}}, id_w[19:12], id_w[20], id_w[30:21], 1'b0};
      bimm = {{20{id_w[31]}}, id_w[7], id_w[30:25], id_w[11:8], 1'b0};
      // JAL or backward branch in decode that the BTB did not steer
      jr_v = id_v && !id_tk &&
             (id_w[6:0] == op_jal || (id_w[6:0] == op_branch && id_w[31]));
      jr_t = id_pc + ((id_w[6:0] == op_jal) ? jimm : bimm);
      // Full PC compare covers index plus tag
      ix  = m_pc[5:2];
      hit = b_v[ix] && (b_pc[ix] == m_pc);
      tk  = hit && b_tk[ix];
      nxt = rows[i].ex_v ? rows[i].ex_t : jr_v ? jr_t : tk ? b_tgt[ix] : m_pc + 32'd4;
      flush = rows[i].ex_v || jr_v;
      if (flush) begin
        id_v = 1'b0;
        id_w = i_nop;
      end else if (!rows[i].stall) begin
        id_v   = 1'b1;
        id_pc  = m_pc;
        id_w   = img[m_pc[9:2]];
        id_hit = hit;
        id_tk  = tk;
        id_tgt = hit ? b_tgt[ix] : '0;
      end
      if (flush || !rows[i].stall) begin
        m_pc = nxt;
      end
      // Training shows up after this cycle's lookup
      if (rows[i].upd_v) begin
        b_v[rows[i].upd_pc[5:2]]   = 1'b1;
        b_pc[rows[i].upd_pc[5:2]]  = rows[i].upd_pc;
        b_tgt[rows[i].upd_pc[5:2]] = rows[i].upd_t;
        b_tk[rows[i].upd_pc[5:2]]  = rows[i].upd_tk;
      end
      rows[i].exp_valid = id_v;
      rows[i].exp_hit   = id_hit;
      rows[i].exp_taken = id_tk;
      rows[i].exp_pc    = id_pc;
      rows[i].exp_instr = id_w;
      rows[i].exp_tgt   = id_tgt;
    end
  endtask

  initial begin
    logic [31:0] r;
    void'($urandom(32'h44f3858f));
    // R-type filler never carries a control opcode
    for (int a = 0; a < imem_words; a++) begin
      r = $urandom();
      img[a[7:0]] = {r[31:7], 7'b0110011};
    end
    img[8'h10] = 32'h0400_00ef;  // 0x40: jal x1, +0x40
    img[8'h21] = 32'h0020_8863;  // 0x84: beq x1, x2, +16
    img[8'h24] = 32'hfe20_8ce3;  // 0x90: beq x1, x2, -8
    img[8'h34] = 32'h0200_00ef;  // 0xd0: jal x1, +0x20
    // test, cycles, stall, ex valid, ex target, train valid, train taken,
    // train pc, train target
    add_row(1, 6, 0, 0, 0, 0, 0, 0, 0);
    add_row(2, 3, 1, 0, 0, 0, 0, 0, 0);
    add_row(2, 2, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, 1, 0, 1, 'h100, 0, 0, 0, 0);
    add_row(3, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(3, 1, 1, 1, 'h110, 0, 0, 0, 0);
    add_row(3, 2, 0, 0, 0, 0, 0, 0, 0);
    add_row(4, 1, 0, 0, 0, 1, 1, 'h120, 'h180);
    // Not-taken entry at 0x184 hits but falls through
    add_row(4, 1, 0, 0, 0, 1, 0, 'h184, 'h200);
    add_row(4, 4, 0, 0, 0, 0, 0, 0, 0);
    // Jump to the JAL and go round the backward loop
    add_row(5, 1, 0, 1, 'h40, 0, 0, 0, 0);
    add_row(5, 11, 0, 0, 0, 0, 0, 0, 0);
    // Execute overrides the loop branch and later the JAL at 0xd0
    add_row(6, 1, 0, 1, 'hd0, 0, 0, 0, 0);
    add_row(6, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(6, 1, 0, 1, 'h20, 0, 0, 0, 0);
    add_row(6, 2, 0, 0, 0, 0, 0, 0, 0);
    build_expected();
    table_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // PC parked at reset_pc while the program loads
    id_stall = 1'b1;
    for (int a = 0; a < imem_words; a++) begin
      imem_wr = '{we: 1'b1, addr: a[7:0], data: img[a[7:0]]};
      @(posedge clk);
      #1;
    end
    imem_wr = '0;
    // Empty decode slot out of reset
    check_val("id_out.valid", 32'h0, {31'b0, id_out.valid});
    check_val("id_out.instr", i_nop, id_out.instr);
    for (int i = 0; i < rows.size(); i++) begin
      id_stall    = rows[i].stall;
      ex_redirect = '{valid: rows[i].ex_v, target: rows[i].ex_t};
      btb_update  = '{valid: rows[i].upd_v, pc: rows[i].upd_pc, target: rows[i].upd_t,
                      taken: rows[i].upd_tk};
      @(posedge clk);
      #1;
      check_val("id_out.valid", {31'b0, rows[i].exp_valid}, {31'b0, id_out.valid});
      check_val("id_out.instr", rows[i].exp_instr, id_out.instr);
      // PC and prediction only mean something beside a valid word
      if (rows[i].exp_valid) begin
        check_val("id_out.pc", rows[i].exp_pc, id_out.pc);
        check_val("id_out.pc_plus4", rows[i].exp_pc + 32'd4, id_out.pc_plus4);
        check_val("id_out.pred.hit", {31'b0, rows[i].exp_hit}, {31'b0, id_out.pred.hit});
        check_val("id_out.pred.taken", {31'b0, rows[i].exp_taken},
                  {31'b0, id_out.pred.taken});
        // Target is only defined on a hit
        if (rows[i].exp_hit) begin
          check_val("id_out.pred.target", rows[i].exp_tgt, id_out.pred.target);
        end
      end
      if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
        $display("test %0d %s: %s, %0d errors", rows[i].test, test_name[rows[i].test],
                 (test_errs == 0) ? "pass" : "fail", test_errs);
        test_errs = 0;
      end
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Load, reset and table cycles plus slack
  initial begin
    wait (table_ready);
    #((imem_words + rows.size() + 20) * 4);
    $display("Timeout: run did not finish in the expected number of cycles");
    $display("Done: errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   id_stall,
  input  fetch_pkg::redirect_t   ex_redirect,
  input  fetch_pkg::btb_update_t btb_update,
  input  fetch_pkg::imem_wr_t    imem_wr,
  output fetch_pkg::if_bundle_t  id_out
);

  import fetch_pkg::*;

  // Fetch address and memory path
  logic [xlen-1:0] pc;
  logic [31:0]     imem_raddr;
  logic [31:0]     imem_rdata;

  // Prediction and IF bundle
  btb_pred_t  pred;
  if_bundle_t if_bundle;

  // Decode-side redirect and the resulting flush
  redirect_t id_redirect;
  logic      flush;

  // Any redirect kills the word in IF
  assign flush = ex_redirect.valid || id_redirect.valid;

  pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (id_stall),
    .ex_redirect (ex_redirect),
    .id_redirect (id_redirect),
    .pred        (pred),
    .pc          (pc)
  );

  // Looked up with the same pc the SRAM sees
  btb u_btb (
    .clk       (clk),
    .rst_n     (rst_n),
    .lookup_pc (pc),
    .pred      (pred),
    .upd       (btb_update)
  );

  stage_if_sram u_stage_if (
    .pc         (pc),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .pred       (pred),
    .if_bundle  (if_bundle)
  );

  imem_sram u_imem (
    .clk   (clk),
    .wr    (imem_wr),
    .raddr (imem_raddr),
    .rdata (imem_rdata)
  );

  if_id_reg u_if_id (
    .clk   (clk),
    .rst_n (rst_n),
    .stall (id_stall),
    .flush (flush),
    .d     (if_bundle),
    .q     (id_out)
  );

  // Static prediction on the registered word
  early_jump u_early_jump (
    .id       (id_out),
    .redirect (id_redirect)
  );

endmodule

`default_nettype wire

// ==== source/early_jump.sv ====
`timescale 1ns/1ps
`default_nettype none

module early_jump (
  input  fetch_pkg::if_bundle_t id,
  output fetch_pkg::redirect_t  redirect
);

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  // Decode view of the ID word
  instr_u iw;

  // Sign-extended offsets
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_b;

  // Candidate kinds
  logic is_jal;
  logic is_bwd_branch;
  logic eligible;

  assign iw.raw = id.instr;

  // J immediate, bit 0 is implied zero
  assign imm_j = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
                  iw.j.imm10_1, 1'b0};

  // B immediate, bit 0 is implied zero
  assign imm_b = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5,
                  iw.b.imm4_1, 1'b0};

  // JAL always jumps
  assign is_jal = (iw.j.opcode == op_jal);

  // Backward branch, sign bit of the offset set
  // Loops close backwards, so predict taken
  assign is_bwd_branch = (iw.b.opcode == op_branch) && iw.b.imm12;

  // Skip bubbles and words the BTB already steered
  assign eligible = id.valid && !id.pred.taken;

  assign redirect.valid  = eligible && (is_jal || is_bwd_branch);
  assign redirect.target = id.pc + (is_jal ? imm_j : imm_b);

endmodule

`default_nettype wire

// ==== source/if_id_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module if_id_reg (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  stall,
  input  logic                  flush,
  input  fetch_pkg::if_bundle_t d,
  output fetch_pkg::if_bundle_t q
);

  import rv_isa_pkg::*;
  import fetch_pkg::*;

  // Control half
  logic        valid_q;
  logic [31:0] instr_q;

  // Payload half
  logic [xlen-1:0] pc_q;
  logic [xlen-1:0] pc_plus4_q;
  btb_pred_t       pred_q;

  // Flush beats stall
  // Bubble is an invalid NOP
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      instr_q <= i_nop;
    end else if (flush) begin
      valid_q <= 1'b0;
      instr_q <= i_nop;
    end else if (!stall) begin
      valid_q <= d.valid;
      instr_q <= d.instr;
    end
  end

  // PCs and prediction only matter alongside a valid word
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q       <= d.pc;
      pc_plus4_q <= d.pc_plus4;
      pred_q     <= d.pred;
    end
  end

  assign q = '{valid: valid_q, pc: pc_q, pc_plus4: pc_plus4_q, instr: instr_q, pred: pred_q};

  // Invalid slots in decode always hold the NOP
  a_bubble_is_nop: assert property (
    @(posedge clk) disable iff (!rst_n)
    !q.valid |-> (q.instr == i_nop)
  ) else $error("if_id_reg: invalid slot holds %h", q.instr);

endmodule

`default_nettype wire

// ==== source/stage_if_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_if_sram (
  input  logic [31:0]           pc,
  output logic [31:0]           imem_raddr,
  input  logic [31:0]           imem_rdata,
  input  fetch_pkg::btb_pred_t  pred,
  output fetch_pkg::if_bundle_t if_bundle
);

  import fetch_pkg::*;

  // Fall-through address
  logic [xlen-1:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  // SRAM answers in the same cycle, so the current pc goes straight out
  assign imem_raddr = pc;

  // Word, both PCs and the prediction line up in one cycle
  // Fetch output is always a real instruction
  always_comb begin
    if_bundle.valid    = 1'b1;
    if_bundle.pc       = pc;
    if_bundle.pc_plus4 = pc_plus4;
    if_bundle.instr    = imem_rdata;
    if_bundle.pred     = pred;
  end

endmodule

`default_nettype wire

// ==== source/pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 stall,
  input  fetch_pkg::redirect_t ex_redirect,
  input  fetch_pkg::redirect_t id_redirect,
  input  fetch_pkg::btb_pred_t pred,
  output logic [31:0]          pc
);

  import fetch_pkg::*;

  logic [xlen-1:0] pc_next;
  logic            redirect_any;

  // Redirects override a stall
  assign redirect_any = ex_redirect.valid || id_redirect.valid;

  // Priority: execute, then decode, then BTB, then sequential
  always_comb begin
    if (ex_redirect.valid) begin
      pc_next = ex_redirect.target;
    end else if (id_redirect.valid) begin
      pc_next = id_redirect.target;
    end else if (pred.hit && pred.taken) begin
      pc_next = pred.target;
    end else begin
      pc_next = pc + 32'd4;
    end
  end

  // PC register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else if (redirect_any || !stall) begin
      pc <= pc_next;
    end
  end

  // Both redirect sources must land on word boundaries
  a_ex_target_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    ex_redirect.valid |-> (ex_redirect.target[1:0] == 2'b00)
  ) else $error("pc_gen: misaligned ex_redirect target %h", ex_redirect.target);

  a_id_target_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    id_redirect.valid |-> (id_redirect.target[1:0] == 2'b00)
  ) else $error("pc_gen: misaligned id_redirect target %h", id_redirect.target);

endmodule

`default_nettype wire

// ==== source/btb.sv ====
`timescale 1ns/1ps
`default_nettype none

module btb (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [31:0]            lookup_pc,
  output fetch_pkg::btb_pred_t   pred,
  input  fetch_pkg::btb_update_t upd
);

  import fetch_pkg::*;

  // Entry state
  logic [btb_entries-1:0] valid_q;
  logic [btb_tw-1:0]      tag_q    [btb_entries];
  logic [xlen-1:0]        target_q [btb_entries];
  logic                   taken_q  [btb_entries];

  // Lookup side fields
  logic [btb_iw-1:0] rd_idx;
  logic [btb_tw-1:0] rd_tag;
  logic              rd_hit;

  // Update side fields
  logic [btb_iw-1:0] wr_idx;
  logic [btb_tw-1:0] wr_tag;

  assign rd_idx = lookup_pc[btb_iw+1:2];
  assign rd_tag = lookup_pc[xlen-1:xlen-btb_tw];
  assign wr_idx = upd.pc[btb_iw+1:2];
  assign wr_tag = upd.pc[xlen-1:xlen-btb_tw];

  // Hit needs a live entry with the same tag
  assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  // Taken only means something on a hit
  assign pred.hit    = rd_hit;
  assign pred.taken  = rd_hit && taken_q[rd_idx];
  assign pred.target = target_q[rd_idx];

  // Valid bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd.valid) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Entry payload, overwrite on every update
  always_ff @(posedge clk) begin
    if (upd.valid) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd.target;
      taken_q[wr_idx]  <= upd.taken;
    end
  end

  // Execute must only train word aligned targets
  a_upd_target_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    upd.valid |-> (upd.target[1:0] == 2'b00)
  ) else $error("btb: misaligned update target %h", upd.target);

endmodule

`default_nettype wire

// ==== source/imem_sram.sv ====
`timescale 1ns/1ps
`default_nettype none

module imem_sram (
  input  logic               clk,
  input  fetch_pkg::imem_wr_t wr,
  input  logic [31:0]        raddr,
  output logic [31:0]        rdata
);

  import fetch_pkg::*;

  // Word storage
  logic [31:0] mem [imem_words];

  // Byte address to word index
  logic [imem_aw-1:0] rindex;

  assign rindex = raddr[imem_aw+1:2];

  // Zero-latency read port
  assign rdata = mem[rindex];

  // Load port, lands on the next edge
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Fetch address from the PC generator stays on word boundaries
  a_raddr_aligned: assert property (@(posedge clk) raddr[1:0] == 2'b00)
    else $error("imem_sram: misaligned read address %h", raddr);

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

  // Datapath width
  localparam int xlen = 32;

  // Instruction SRAM geometry, in 32-bit words
  localparam int imem_words = 256;
  localparam int imem_aw    = 8;

  // BTB geometry
  // Index from pc[5:2], tag from pc[31:6]
  localparam int btb_entries = 16;
  localparam int btb_iw      = 4;
  localparam int btb_tw      = 26;

  // First fetch address out of reset
  localparam logic [xlen-1:0] reset_pc = '0;

  // Single-cycle redirect pulse
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] target;
  } redirect_t;

  // Training write from execute
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] target;
    logic            taken;
  } btb_update_t;

  // BTB lookup result
  typedef struct packed {
    logic            hit;
    logic            taken;
    logic [xlen-1:0] target;
  } btb_pred_t;

  // Everything fetch hands to decode
  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] pc_plus4;
    logic [31:0]     instr;
    btb_pred_t       pred;
  } if_bundle_t;

  // Program load port, word addressed
  typedef struct packed {
    logic               we;
    logic [imem_aw-1:0] addr;
    logic [31:0]        data;
  } imem_wr_t;

endpackage

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // Major opcodes the front end cares about
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // addi x0, x0, 0
  localparam logic [31:0] i_nop = 32'h0000_0013;

  // J-type layout, MSB first
  // Immediate bits are scattered as imm[20|10:1|11|19:12]
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fields_t;

  // B-type layout, MSB first
  // Upper immediate is imm[12|10:5], lower is imm[4:1|11]
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fields_t;

  // One instruction word seen three ways
  // Opcode sits in bits 6:0 in both decoded views
  typedef union packed {
    logic [31:0] raw;
    j_fields_t   j;
    b_fields_t   b;
  } instr_u;

endpackage

`default_nettype wire
